// ==== bench/spn_model.svh ====
`ifndef SPN_MODEL_SVH
`define SPN_MODEL_SVH

//////////////////////////////////////////////////
// GF(4) by logarithms
//////////////////////////////////////////////////

// in the normal basis 3 is the unit, 1 is w and 2 is w^2.
function automatic int gf4_log(input logic [1:0] a);
  case (a)
    2'd3: return 0;
    2'd1: return 1;
    default: return 2;
  endcase
endfunction

function automatic logic [1:0] gf4_exp(input int e);
  case (e % 3)
    0: return 2'd3;
    1: return 2'd1;
    default: return 2'd2;
  endcase
endfunction

function automatic logic [1:0] gf4_times(input logic [1:0] a, input logic [1:0] b);
  if (a == 2'd0 || b == 2'd0) begin
    return 2'd0;
  end
  return gf4_exp(gf4_log(a) + gf4_log(b));
endfunction

// output bit i is the parity of the input bits picked by masks[i].
function automatic logic [5:0] bit_matrix(input logic [5:0] a, input logic [35:0] masks);
  logic [5:0] r;
  for (int i = 0; i < 6; i++) begin
    r[i] = ^(a & masks[6*i +: 6]);
  end
  return r;
endfunction

function automatic logic [5:0] ref_sbox(input logic [5:0] x);
  logic [1:0] d [3];
  logic [1:0] s [3];
  logic [1:0] cube [3];
  logic [1:0] q [15];
  logic [5:0] t;
  t = bit_matrix(x, {6'h31, 6'h21, 6'h03, 6'h35, 6'h09, 6'h27});  // into the tower basis.
  for (int i = 0; i < 3; i++) begin
    d[i] = t[2*i +: 2];
    s[i] = gf4_times(d[i], d[i]);
    cube[i] = gf4_times(d[i], s[i]);
  end
  q[0] = s[0];
  q[1] = s[1];
  q[2] = s[2];
  q[3] = gf4_times(cube[1], s[0]);
  q[4] = gf4_times(cube[2], s[0]);
  q[5] = gf4_times(cube[0], s[1]);
  q[6] = gf4_times(cube[2], s[1]);
  q[7] = gf4_times(cube[0], s[2]);
  q[8] = gf4_times(cube[1], s[2]);
  q[9] = gf4_times(d[0], d[1]);
  q[10] = gf4_times(d[0], d[2]);
  q[11] = gf4_times(d[1], d[2]);
  q[12] = gf4_times(d[0], gf4_times(s[1], s[2]));
  q[13] = gf4_times(d[1], gf4_times(s[0], s[2]));
  q[14] = gf4_times(d[2], gf4_times(s[0], s[1]));
  t[5:4] = q[1] ^ q[2] ^ q[4] ^ q[5] ^ q[6] ^ q[9] ^ q[11] ^ q[12] ^ q[13];
  t[3:2] = q[0] ^ q[1] ^ q[3] ^ q[4] ^ q[8] ^ q[9] ^ q[10] ^ q[12] ^ q[14];
  t[1:0] = q[0] ^ q[2] ^ q[5] ^ q[7] ^ q[8] ^ q[10] ^ q[11] ^ q[13] ^ q[14];
  t = bit_matrix(t, {6'h36, 6'h05, 6'h32, 6'h22, 6'h08, 6'h2E});
  return t ^ {6{x[2] ^ x[4]}};
endfunction

//////////////////////////////////////////////////
// key schedule and encryption
//////////////////////////////////////////////////

function automatic logic [23:0] next_key(input logic [23:0] k, input int r);
  logic [23:0] rot;
  rot = {k[17:0], k[23:18]};
  rot[23:18] = ref_sbox(rot[23:18]);
  return rot ^ 24'(r);
endfunction

function automatic logic [23:0] ref_encrypt(input logic [23:0] pt, input logic [23:0] key);
  logic [23:0] s;
  logic [23:0] p;
  logic [23:0] k;
  s = pt ^ key;
  k = key;
  for (int r = 1; r <= `NUM_ROUNDS; r++) begin
    for (int w = 0; w < 4; w++) begin
      s[6*w +: 6] = ref_sbox(s[6*w +: 6]);
    end
    for (int w = 0; w < 4; w++) begin
      for (int b = 0; b < 6; b++) begin
        p[4*b + w] = s[6*w + b];
      end
    end
    k = next_key(k, r);
    s = p ^ k;
  end
  return s;
endfunction

`endif

// ==== bench/tb_spn_cipher.sv ====
`timescale 1ns/100ps
`include "spn_defs.svh"

module tb_spn_cipher;

  localparam int NUM_ENTRIES = 25;
  localparam int NUM_TESTS   = NUM_ENTRIES + 3;
  localparam int DONE_LIMIT  = `NUM_ROUNDS * 12 + 10;
  localparam real WATCHDOG_NS = NUM_TESTS * DONE_LIMIT * 2 * 40.0;

  logic        clk;
  logic        reset;
  logic        start;
  logic [23:0] block_in;
  logic [23:0] key_in;
  logic        busy;
  logic        done;
  logic [23:0] block_out;

  string       names [NUM_ENTRIES];
  logic [23:0] pt_tab [NUM_ENTRIES];
  logic [23:0] key_tab [NUM_ENTRIES];
  logic [23:0] exp_tab [NUM_ENTRIES];
  logic [23:0] got_tab [NUM_ENTRIES];
  logic [31:0] lfsr_state;
  int          errors;
  int          passed;
  int          failed;

  `include "spn_model.svh"

  spn_cipher_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .block_in  (block_in),
    .key_in    (key_in),
    .busy      (busy),
    .done      (done),
    .block_out (block_out)
  );

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output logic [23:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[22:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [23:0] expected,
                             input logic [23:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("PASS %s", name);
      passed++;
    end else begin
      $display("FAIL %s", name);
      failed++;
    end
  endtask

  task automatic wait_done(input string name);
    int cycles;
    cycles = 0;
    while (!done && cycles < DONE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      $display("%s: done never came within %0d cycles", name, DONE_LIMIT);
      errors++;
    end
  endtask

  // checks the done pulse, busy and a stable result once done is seen.
  task automatic check_finish(input string name, input logic [23:0] expected);
    logic [23:0] held;
    held = block_out;
    check_value({name, " block_out"}, expected, block_out);
    check_value({name, " busy at done"}, 24'd0, 24'(busy));
    repeat (3) begin
      @(negedge clk);
      check_value({name, " done width"}, 24'd0, 24'(done));
      check_value({name, " held block_out"}, held, block_out);
    end
  endtask

  task automatic encrypt_entry(input int idx);
    @(negedge clk);
    start    = 1'b1;
    block_in = pt_tab[idx];
    key_in   = key_tab[idx];
    @(negedge clk);
    start = 1'b0;
    check_value({names[idx], " busy"}, 24'd1, 24'(busy));
    wait_done(names[idx]);
    got_tab[idx] = block_out;
    if (done) begin
      check_finish(names[idx], exp_tab[idx]);
    end
  endtask

  //////////////////////////////////////////////////
  // watchdog
  //////////////////////////////////////////////////

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run went on past %0.0f ns", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    int e0;
    logic [23:0] v;
    clk = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    block_in = '0;
    key_in = '0;
    errors = 0;
    passed = 0;
    failed = 0;
    lfsr_state = 32'd89695;

    names[0] = "all_zero";
    pt_tab[0] = 24'h000000;
    key_tab[0] = 24'h000000;
    names[1] = "all_one";
    pt_tab[1] = 24'hFFFFFF;
    key_tab[1] = 24'hFFFFFF;
    for (int i = 0; i < 4; i++) begin
      names[2+i] = $sformatf("walk_word%0d", i);
      pt_tab[2+i] = 24'h3F << (6*i);
      key_tab[2+i] = 24'h000001 << (6*((i+1) % 4));
    end
    for (int i = 0; i < 16; i++) begin
      names[6+i] = $sformatf("random%0d", i);
      random_bits(24, v);
      pt_tab[6+i] = v;
      random_bits(24, v);
      key_tab[6+i] = v;
    end
    for (int i = 0; i < 3; i++) begin
      names[22+i] = $sformatf("same_key_word%0d", i);
      pt_tab[22+i] = 24'h123456 ^ (24'h000001 << (6*i));
      key_tab[22+i] = 24'h5A5A5A;
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      exp_tab[i] = ref_encrypt(pt_tab[i], key_tab[i]);
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("idle after reset", 24'd0, {22'd0, busy, done});

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      e0 = errors;
      encrypt_entry(i);
      end_test(names[i], e0);
    end

    e0 = errors;
    for (int i = 22; i < NUM_ENTRIES; i++) begin
      for (int j = i + 1; j < NUM_ENTRIES; j++) begin
        if (got_tab[i] === got_tab[j]) begin
          $display("same key: %s and %s gave the same ciphertext", names[i], names[j]);
          errors++;
        end
      end
    end
    end_test("same_key_distinct", e0);

    // a second start during the run must not disturb the first block.
    e0 = errors;
    @(negedge clk);
    start = 1'b1;
    block_in = 24'hABCDEF;
    key_in = 24'h13579B;
    @(negedge clk);
    start = 1'b0;
    repeat (3) @(negedge clk);
    start = 1'b1;
    block_in = 24'h0F0F0F;
    @(negedge clk);
    start = 1'b0;
    wait_done("start_while_busy");
    if (done) begin
      check_finish("start_while_busy", ref_encrypt(24'hABCDEF, 24'h13579B));
    end
    end_test("start_while_busy", e0);

    e0 = errors;
    @(negedge clk);
    start = 1'b1;
    block_in = 24'h2468AC;
    key_in = 24'hFEDCBA;
    @(negedge clk);
    start = 1'b0;
    repeat (10) @(negedge clk);
    check_value("reset_mid busy before reset", 24'd1, 24'(busy));
    reset = 1'b1;
    @(negedge clk);
    check_value("reset_mid busy", 24'd0, 24'(busy));
    check_value("reset_mid done", 24'd0, 24'(done));
    @(negedge clk);
    reset = 1'b0;
    encrypt_entry(7);
    end_test("reset_mid_encryption", e0);

    $display("%0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cipher testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_spn_cipher -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== src/cipher_pkg.sv ====
`include "spn_defs.svh"

package cipher_pkg;

  typedef logic [`BLOCK_W-1:0] block_t;   // cipher state and ciphertext.
  typedef logic [`BLOCK_W-1:0] key_t;     // cipher key and round key.
  typedef logic [2:0]          round_t;   // round number, 0 to NUM_ROUNDS.

  typedef enum logic [2:0] {
    RD_IDLE,
    RD_WAIT_KEY,
    RD_SUBST,
    RD_MIX,
    RD_DONE
  } rd_state_e;

  typedef enum logic [1:0] {
    KS_IDLE,
    KS_LOOKUP,
    KS_READY
  } ks_state_e;

endpackage

// ==== src/gf_pkg.sv ====
`include "spn_defs.svh"

package gf_pkg;

  // element of GF(4) in the tower basis.
  typedef logic [1:0] gf4_t;

  // element of GF((2^2)^3), as three GF(4) digits when in tower form.
  typedef logic [`SBOX_W-1:0] gf64_t;

endpackage

// ==== src/key_schedule.sv ====
`timescale 1ns/100ps
`include "spn_defs.svh"

module key_schedule (
  input  logic             clk,
  input  logic             reset,
  input  logic             load_key,
  input  cipher_pkg::key_t key_in,
  input  logic             key_step,
  input  logic             gnt_ks,
  input  gf_pkg::gf64_t    sbox_out,
  output logic             req_ks,
  output gf_pkg::gf64_t    sbox_in_ks,
  output logic             key_ready,
  output cipher_pkg::key_t round_key
);

  localparam cipher_pkg::round_t LAST_ROUND = cipher_pkg::round_t'(`NUM_ROUNDS);

  cipher_pkg::ks_state_e ks_state;
  cipher_pkg::round_t    ks_round;     // round of the key now held in round_key.
  cipher_pkg::round_t    next_round;
  cipher_pkg::key_t      rotated;

  assign next_round = ks_round + 1'b1;

  // rotate left by one word, then the new top word goes through the S-box.
  assign rotated    = {round_key[`BLOCK_W-`SBOX_W-1:0], round_key[`BLOCK_W-1 -: `SBOX_W]};
  assign sbox_in_ks = rotated[`BLOCK_W-1 -: `SBOX_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      ks_state <= cipher_pkg::KS_IDLE;
      ks_round <= '0;
    end else if (load_key) begin
      ks_state <= cipher_pkg::KS_LOOKUP;
      ks_round <= '0;
    end else begin
      case (ks_state)
        cipher_pkg::KS_LOOKUP: begin
          if (gnt_ks) begin
            ks_state <= cipher_pkg::KS_READY;
            ks_round <= next_round;
          end
        end
        cipher_pkg::KS_READY: begin
          if (key_step) begin
            ks_state <= (ks_round == LAST_ROUND) ? cipher_pkg::KS_IDLE : cipher_pkg::KS_LOOKUP;
          end
        end
        default: ks_state <= cipher_pkg::KS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load_key) begin
      round_key <= key_in;
    end else if (ks_state == cipher_pkg::KS_LOOKUP && gnt_ks) begin
      round_key <= {sbox_out, rotated[`BLOCK_W-`SBOX_W-1:0]} ^ cipher_pkg::key_t'(next_round);
    end
  end

  assign req_ks    = (ks_state == cipher_pkg::KS_LOOKUP);
  assign key_ready = (ks_state == cipher_pkg::KS_READY);

endmodule

// ==== src/round_datapath.sv ====
`timescale 1ns/100ps
`include "spn_defs.svh"

module round_datapath (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  cipher_pkg::block_t block_in,
  input  cipher_pkg::key_t   key_in,
  input  cipher_pkg::key_t   round_key,
  input  logic               key_ready,
  input  logic               gnt_rd,
  input  gf_pkg::gf64_t      sbox_out,
  output logic               req_rd,
  output gf_pkg::gf64_t      sbox_in_rd,
  output logic               load_key,
  output logic               key_step,
  output logic               busy,
  output logic               done,
  output cipher_pkg::block_t block_out
);

  localparam int WORD_IDX_W = $clog2(`BLOCK_WORDS);
  localparam logic [WORD_IDX_W-1:0] LAST_WORD = WORD_IDX_W'(`BLOCK_WORDS - 1);
  localparam cipher_pkg::round_t LAST_ROUND = cipher_pkg::round_t'(`NUM_ROUNDS - 1);

  cipher_pkg::rd_state_e   rd_state;
  cipher_pkg::block_t      cipher_state;
  cipher_pkg::round_t      round_cnt;
  logic [WORD_IDX_W-1:0]   word_idx;

  // bit 6w+b of the state moves to bit 4b+w.
  function automatic cipher_pkg::block_t transpose(input cipher_pkg::block_t s);
    cipher_pkg::block_t t;
    t = '0;
    for (int w = 0; w < `BLOCK_WORDS; w++) begin
      for (int b = 0; b < `SBOX_W; b++) begin
        t[`BLOCK_WORDS*b + w] = s[`SBOX_W*w + b];
      end
    end
    return t;
  endfunction

  //////////////////////////////////////////////////
  // round control
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_state  <= cipher_pkg::RD_IDLE;
      round_cnt <= '0;
      word_idx  <= '0;
    end else begin
      case (rd_state)
        cipher_pkg::RD_IDLE, cipher_pkg::RD_DONE: begin
          if (load_key) begin
            rd_state  <= cipher_pkg::RD_SUBST;
            round_cnt <= '0;
            word_idx  <= '0;
          end else begin
            rd_state <= cipher_pkg::RD_IDLE;
          end
        end
        cipher_pkg::RD_SUBST: begin
          if (gnt_rd) begin
            word_idx <= word_idx + 1'b1;  // wraps to word 0 for the next round.
            if (word_idx == LAST_WORD) begin
              rd_state <= cipher_pkg::RD_WAIT_KEY;
            end
          end
        end
        cipher_pkg::RD_WAIT_KEY: begin
          if (key_ready) begin
            rd_state <= cipher_pkg::RD_MIX;
          end
        end
        cipher_pkg::RD_MIX: begin
          round_cnt <= round_cnt + 1'b1;
          rd_state  <= (round_cnt == LAST_ROUND) ? cipher_pkg::RD_DONE : cipher_pkg::RD_SUBST;
        end
        default: rd_state <= cipher_pkg::RD_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // cipher state
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load_key) begin
      cipher_state <= block_in ^ key_in;  // whitening with k0.
    end else if (rd_state == cipher_pkg::RD_SUBST && gnt_rd) begin
      cipher_state[word_idx*`SBOX_W +: `SBOX_W] <= sbox_out;
    end else if (rd_state == cipher_pkg::RD_MIX) begin
      cipher_state <= transpose(cipher_state) ^ round_key;
    end
  end

  assign busy       = (rd_state != cipher_pkg::RD_IDLE) && (rd_state != cipher_pkg::RD_DONE);
  assign load_key   = start && !busy;  // a start while busy is dropped.
  assign key_step   = (rd_state == cipher_pkg::RD_MIX);
  assign done       = (rd_state == cipher_pkg::RD_DONE);
  assign req_rd     = (rd_state == cipher_pkg::RD_SUBST);
  assign sbox_in_rd = cipher_state[word_idx*`SBOX_W +: `SBOX_W];
  assign block_out  = cipher_state;

endmodule

// ==== src/sbox_arbiter.sv ====
`timescale 1ns/100ps

module sbox_arbiter (
  input  logic          clk,
  input  logic          reset,
  input  logic          req_rd,
  input  gf_pkg::gf64_t sbox_in_rd,
  input  logic          req_ks,
  input  gf_pkg::gf64_t sbox_in_ks,
  output logic          gnt_rd,
  output logic          gnt_ks,
  output gf_pkg::gf64_t sbox_out
);

  logic          last_rd;   // high when the datapath held the last grant.
  gf_pkg::gf64_t sbox_in;

  //////////////////////////////////////////////////
  // round-robin grant
  //////////////////////////////////////////////////

  // on conflict the side that was not served last wins.
  assign gnt_rd = req_rd && (!req_ks || !last_rd);
  assign gnt_ks = req_ks && !gnt_rd;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_rd <= 1'b0;
    end else if (gnt_rd || gnt_ks) begin
      last_rd <= gnt_rd;
    end
  end

  //////////////////////////////////////////////////
  // shared S-box
  //////////////////////////////////////////////////

  assign sbox_in = gnt_ks ? sbox_in_ks : sbox_in_rd;

  sbox_smss sbox_i (
    .x (sbox_in),
    .y (sbox_out)
  );

endmodule

// ==== src/sbox_smss.sv ====
`timescale 1ns/100ps
`include "spn_defs.svh"

module sbox_smss (
  input  gf_pkg::gf64_t x,
  output gf_pkg::gf64_t y
);

  //////////////////////////////////////////////////
  // GF(4) helpers
  //////////////////////////////////////////////////

  function automatic gf_pkg::gf4_t gf4_sq(input gf_pkg::gf4_t a);
    return {a[0], a[1]};  // squaring swaps the two coordinates.
  endfunction

  function automatic gf_pkg::gf4_t gf4_mul(input gf_pkg::gf4_t a, input gf_pkg::gf4_t b);
    logic t;
    t = (a[0] & b[1]) ^ (a[1] & b[0]);
    return {(a[0] & b[0]) ^ t, (a[1] & b[1]) ^ t};
  endfunction

  // a^3 is 1 for every nonzero a, so this passes b through or clears it.
  function automatic gf_pkg::gf4_t gf4_scale(input gf_pkg::gf4_t a, input gf_pkg::gf4_t b);
    logic t;
    t = a[0] | a[1];
    return b & {2{t}};
  endfunction

  //////////////////////////////////////////////////
  // basis changes
  //////////////////////////////////////////////////

  function automatic gf_pkg::gf64_t iso(input gf_pkg::gf64_t a);
    gf_pkg::gf64_t b;
    b[0] = a[0] ^ a[1] ^ a[2] ^ a[5];
    b[1] = a[0] ^ a[3];
    b[2] = a[0] ^ a[2] ^ a[4] ^ a[5];
    b[3] = a[0] ^ a[1];
    b[4] = a[0] ^ a[5];
    b[5] = a[0] ^ a[4] ^ a[5];
    return b;
  endfunction

  function automatic gf_pkg::gf64_t inv_iso(input gf_pkg::gf64_t a);
    gf_pkg::gf64_t b;
    b[0] = a[1] ^ a[2] ^ a[3] ^ a[5];
    b[1] = a[3];
    b[2] = a[1] ^ a[5];
    b[3] = a[1] ^ a[4] ^ a[5];
    b[4] = a[0] ^ a[2];
    b[5] = a[1] ^ a[2] ^ a[4] ^ a[5];
    return b;
  endfunction

  //////////////////////////////////////////////////
  // power 38 in the tower field
  //////////////////////////////////////////////////

  function automatic gf_pkg::gf64_t pow38(input gf_pkg::gf64_t a);
    gf_pkg::gf4_t d0, d1, d2;
    gf_pkg::gf4_t s0, s1, s2;
    gf_pkg::gf4_t q [0:14];
    gf_pkg::gf4_t hi, mid, lo;
    d0 = a[1:0];
    d1 = a[3:2];
    d2 = a[5:4];
    s0 = gf4_sq(d0);
    s1 = gf4_sq(d1);
    s2 = gf4_sq(d2);
    q[0]  = s0;
    q[1]  = s1;
    q[2]  = s2;
    q[3]  = gf4_scale(d1, s0);
    q[4]  = gf4_scale(d2, s0);
    q[5]  = gf4_scale(d0, s1);
    q[6]  = gf4_scale(d2, s1);
    q[7]  = gf4_scale(d0, s2);
    q[8]  = gf4_scale(d1, s2);
    q[9]  = gf4_mul(d0, d1);
    q[10] = gf4_mul(d0, d2);
    q[11] = gf4_mul(d1, d2);
    q[12] = gf4_mul(d0, gf4_mul(s1, s2));  // cross terms of degree three.
    q[13] = gf4_mul(d1, gf4_mul(s0, s2));
    q[14] = gf4_mul(d2, gf4_mul(s0, s1));
    hi  = q[1] ^ q[2] ^ q[4] ^ q[5] ^ q[6] ^ q[9] ^ q[11] ^ q[12] ^ q[13];
    lo  = q[0] ^ q[2] ^ q[5] ^ q[7] ^ q[8] ^ q[10] ^ q[11] ^ q[13] ^ q[14];
    mid = q[0] ^ q[1] ^ q[3] ^ q[4] ^ q[8] ^ q[9] ^ q[10] ^ q[12] ^ q[14];
    return {hi, mid, lo};
  endfunction

  gf_pkg::gf64_t tower_in;
  gf_pkg::gf64_t tower_out;
  gf_pkg::gf64_t mapped;
  logic          parity;

  assign tower_in  = iso(x);
  assign tower_out = pow38(tower_in);
  assign mapped    = inv_iso(tower_out);
  assign parity    = x[2] ^ x[4];           // affine term from the input word.
  assign y         = mapped ^ {`SBOX_W{parity}};

endmodule

// ==== src/spn_cipher_top.sv ====
`timescale 1ns/100ps

module spn_cipher_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  cipher_pkg::block_t block_in,
  input  cipher_pkg::key_t   key_in,
  output logic               busy,
  output logic               done,
  output cipher_pkg::block_t block_out
);

  //////////////////////////////////////////////////
  // peer-to-peer and arbiter wires
  //////////////////////////////////////////////////

  logic             req_rd;
  logic             gnt_rd;
  gf_pkg::gf64_t    sbox_in_rd;
  logic             req_ks;
  logic             gnt_ks;
  gf_pkg::gf64_t    sbox_in_ks;
  gf_pkg::gf64_t    sbox_out;     // broadcast to both requesters.
  logic             load_key;
  logic             key_step;
  logic             key_ready;
  cipher_pkg::key_t round_key;

  round_datapath round_i (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .block_in   (block_in),
    .key_in     (key_in),
    .round_key  (round_key),
    .key_ready  (key_ready),
    .gnt_rd     (gnt_rd),
    .sbox_out   (sbox_out),
    .req_rd     (req_rd),
    .sbox_in_rd (sbox_in_rd),
    .load_key   (load_key),
    .key_step   (key_step),
    .busy       (busy),
    .done       (done),
    .block_out  (block_out)
  );

  key_schedule key_i (
    .clk        (clk),
    .reset      (reset),
    .load_key   (load_key),
    .key_in     (key_in),
    .key_step   (key_step),
    .gnt_ks     (gnt_ks),
    .sbox_out   (sbox_out),
    .req_ks     (req_ks),
    .sbox_in_ks (sbox_in_ks),
    .key_ready  (key_ready),
    .round_key  (round_key)
  );

  sbox_arbiter arb_i (
    .clk        (clk),
    .reset      (reset),
    .req_rd     (req_rd),
    .sbox_in_rd (sbox_in_rd),
    .req_ks     (req_ks),
    .sbox_in_ks (sbox_in_ks),
    .gnt_rd     (gnt_rd),
    .gnt_ks     (gnt_ks),
    .sbox_out   (sbox_out)
  );

endmodule

// ==== src/spn_defs.svh ====
`ifndef SPN_DEFS_SVH
`define SPN_DEFS_SVH

//////////////////////////////////////////////////
// cipher geometry
//////////////////////////////////////////////////

`define SBOX_W 6          // one S-box word, an element of GF(64).

`define BLOCK_WORDS 4     // words per block and per key.

`define BLOCK_W 24        // block and key width, BLOCK_WORDS * SBOX_W.

//////////////////////////////////////////////////
// round count
//////////////////////////////////////////////////

`define NUM_ROUNDS 6      // must fit in the 3-bit round counter.

`endif

// ==== tb.f ====
+incdir+src
+incdir+bench
src/gf_pkg.sv
src/cipher_pkg.sv
src/sbox_smss.sv
src/sbox_arbiter.sv
src/round_datapath.sv
src/key_schedule.sv
src/spn_cipher_top.sv
bench/tb_spn_cipher.sv
